//--- hw/udp_trigger_macros.svh
// ------------------------------------------------------------
// stream widths, header field positions and match values
// for the udp trigger tap, plus queue depth and counter width
// ------------------------------------------------------------
`ifndef UDP_TRIGGER_MACROS_SVH
`define UDP_TRIGGER_MACROS_SVH

// axi stream widths
`define UDPT_DATA_W 256
`define UDPT_KEEP_W 32
`define UDPT_USER_W 128

// field offsets inside a beat
// ethertype and ip protocol sit in beat 0, udp dport in beat 1
`define UDPT_ETH_TYPE_POS 96
`define UDPT_IP_PROTO_POS 184
`define UDPT_UDP_DPORT_POS 32

// match values, ethertype in wire byte order
`define UDPT_IP_TYPE 16'h0008
`define UDPT_UDP_PROTO 8'h11
`define UDPT_TRIG_PORT 16'd12345

// low bits of a beat that complete a sample
`define UDPT_SPLIT 80

`define UDPT_QUEUE_DEPTH 4
`define UDPT_CNT_W 32

`endif

//--- hw/stream_pkg.sv
// ------------------------------------------------------------
// axi stream side types
// data, keep and user vectors and the packed beat struct
// ------------------------------------------------------------
`include "udp_trigger_macros.svh"

package stream_pkg;

	typedef logic [`UDPT_DATA_W-1:0] tdata_t;
	typedef logic [`UDPT_KEEP_W-1:0] tkeep_t;
	typedef logic [`UDPT_USER_W-1:0] tuser_t;

	// one beat minus the handshake, which travels beside it
	typedef struct packed {
		tdata_t data;
		tkeep_t keep;
		tuser_t user;
		logic   last;
	} axis_beat_t;

endpackage

//--- hw/trigger_pkg.sv
// ------------------------------------------------------------
// trigger side types
// sample and carried payload, stat counters and their bundle,
// parser state encoding
// ------------------------------------------------------------
`include "udp_trigger_macros.svh"

package trigger_pkg;

	typedef logic [`UDPT_DATA_W-1:0] sample_t;

	// upper part of a beat kept for the next sample
	typedef logic [`UDPT_DATA_W-`UDPT_SPLIT-1:0] held_t;

	// msb is a sticky overflow flag above the count
	typedef logic [`UDPT_CNT_W-1:0] stat_cnt_t;

	typedef struct packed {
		stat_cnt_t frames_in;
		stat_cnt_t frames_matched;
		stat_cnt_t samples_queued;
		stat_cnt_t samples_dropped;
	} stats_t;

	// position of the parser inside a frame
	typedef enum logic [1:0] {
		HDR0,
		HDR1,
		BODY,
		SKIP
	} parse_state_t;

endpackage

//--- hw/frame_ctrl.sv
// ------------------------------------------------------------
// frame parser FSM
// tracks beat position, enables header checks and sampling,
// flags frame end and matched frame end
// ------------------------------------------------------------
`timescale 1ns/1ps

module frame_ctrl (
	input  logic axis_aclk,
	input  logic cf_rstn,
	input  logic beat_fire_i,
	input  logic beat_last_i,
	input  logic ip_udp_ok_i,
	input  logic port_ok_i,
	output logic hdr0_en_o,
	output logic hdr1_en_o,
	output logic sample_en_o,
	output logic load_en_o,
	output logic frame_done_o,
	output logic frame_matched_o
);

	trigger_pkg::parse_state_t state_q;
	trigger_pkg::parse_state_t state_d;
	logic hdr_ok;
	logic body_fire;

	// both flags are registered by the time BODY is entered
	assign hdr_ok = ip_udp_ok_i & port_ok_i;
	assign body_fire = beat_fire_i & (state_q == trigger_pkg::BODY) & hdr_ok;

	always_comb begin
		state_d = state_q;
		if (beat_fire_i) begin
			if (beat_last_i) begin
				state_d = trigger_pkg::HDR0;
			end else begin
				case (state_q)
					trigger_pkg::HDR0: state_d = trigger_pkg::HDR1;
					trigger_pkg::HDR1: state_d = trigger_pkg::BODY;
					// header mismatch, ignore rest of frame
					trigger_pkg::BODY: state_d = hdr_ok ? trigger_pkg::BODY : trigger_pkg::SKIP;
					default: state_d = trigger_pkg::SKIP;
				endcase
			end
		end
	end

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			state_q <= trigger_pkg::HDR0;
		end else begin
			state_q <= state_d;
		end
	end

	assign hdr0_en_o = beat_fire_i & (state_q == trigger_pkg::HDR0);
	assign hdr1_en_o = beat_fire_i & (state_q == trigger_pkg::HDR1);
	// beat 1 payload is loaded for every frame
	assign load_en_o = hdr1_en_o;
	assign sample_en_o = body_fire;

	assign frame_done_o = beat_fire_i & beat_last_i;
	assign frame_matched_o = body_fire & beat_last_i;

endmodule

//--- hw/header_match.sv
// ------------------------------------------------------------
// header field compare
// ethertype and protocol on beat 0, dest port on beat 1,
// results held as per-frame flags
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "udp_trigger_macros.svh"

module header_match (
	input  logic              axis_aclk,
	input  logic              cf_rstn,
	input  stream_pkg::tdata_t beat_i,
	input  logic              hdr0_en_i,
	input  logic              hdr1_en_i,
	output logic              ip_udp_ok_o,
	output logic              port_ok_o
);

	logic eth_hit;
	logic proto_hit;
	logic port_hit;

	assign eth_hit = beat_i[`UDPT_ETH_TYPE_POS +: 16] == `UDPT_IP_TYPE;
	assign proto_hit = beat_i[`UDPT_IP_PROTO_POS +: 8] == `UDPT_UDP_PROTO;
	assign port_hit = beat_i[`UDPT_UDP_DPORT_POS +: 16] == `UDPT_TRIG_PORT;

	// flags stay put until the next frame's header beats
	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			ip_udp_ok_o <= 1'b0;
			port_ok_o <= 1'b0;
		end else begin
			if (hdr0_en_i) begin
				ip_udp_ok_o <= eth_hit & proto_hit;
			end
			if (hdr1_en_i) begin
				port_ok_o <= port_hit;
			end
		end
	end

endmodule

//--- hw/payload_align.sv
// ------------------------------------------------------------
// payload realignment
// carries the top of each beat into the next and emits
// 256-bit samples from low current bits over held bits
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "udp_trigger_macros.svh"

module payload_align (
	input  logic                 axis_aclk,
	input  logic                 cf_rstn,
	input  stream_pkg::tdata_t   beat_i,
	input  logic                 load_en_i,
	input  logic                 sample_en_i,
	output trigger_pkg::sample_t sample_o,
	output logic                 sample_valid_o
);

	trigger_pkg::held_t held_q;

	// data path
	always_ff @(posedge axis_aclk) begin
		if (load_en_i || sample_en_i) begin
			held_q <= beat_i[`UDPT_DATA_W-1:`UDPT_SPLIT];
		end
		if (sample_en_i) begin
			// low bits of this beat land above the previous beat's top
			sample_o <= {beat_i[`UDPT_SPLIT-1:0], held_q};
		end
	end

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			sample_valid_o <= 1'b0;
		end else begin
			sample_valid_o <= sample_en_i;
		end
	end

endmodule

//--- hw/sample_queue.sv
// ------------------------------------------------------------
// sample FIFO with drop on full
// head entry presented on a four-phase req/ack port
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "udp_trigger_macros.svh"

module sample_queue #(
	parameter int DEPTH = `UDPT_QUEUE_DEPTH
) (
	input  logic                 axis_aclk,
	input  logic                 cf_rstn,
	input  trigger_pkg::sample_t sample_i,
	input  logic                 sample_valid_i,
	output trigger_pkg::sample_t sample_o,
	output logic                 sample_req_o,
	input  logic                 sample_ack_i,
	output logic                 queued_o,
	output logic                 dropped_o
);

	localparam int AW = $clog2(DEPTH);

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_REQ,
		PH_RELEASE
	} phase_t;

	trigger_pkg::sample_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	phase_t        phase_q;
	logic          full;
	logic          push;
	logic          pop;

	assign full = count == (AW+1)'(DEPTH);
	assign push = sample_valid_i & ~full;
	assign pop = (phase_q == PH_REQ) & sample_ack_i;

	assign queued_o = push;
	assign dropped_o = sample_valid_i & full;

	always_ff @(posedge axis_aclk) begin
		if (push) begin
			mem[wr_ptr] <= sample_i;
		end
	end

	// head stays fixed while req is up, writes go to free slots
	assign sample_o = mem[rd_ptr];
	assign sample_req_o = phase_q == PH_REQ;

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			phase_q <= PH_IDLE;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + push - pop;

			case (phase_q)
				PH_IDLE: begin
					if (count != '0 && !sample_ack_i) begin
						phase_q <= PH_REQ;
					end
				end
				// ack seen, entry popped, req falls
				PH_REQ: begin
					if (sample_ack_i) begin
						phase_q <= PH_RELEASE;
					end
				end
				// wait for consumer to drop ack
				default: begin
					if (!sample_ack_i) begin
						phase_q <= PH_IDLE;
					end
				end
			endcase
		end
	end

endmodule

//--- hw/traffic_counters.sv
// ------------------------------------------------------------
// traffic statistics
// frame, match, queued and dropped counters, each with
// a sticky wrap flag in the msb, cleared by clear_i
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "udp_trigger_macros.svh"

module traffic_counters (
	input  logic                axis_aclk,
	input  logic                cf_rstn,
	input  logic                clear_i,
	input  logic                frame_done_i,
	input  logic                frame_matched_i,
	input  logic                queued_i,
	input  logic                dropped_i,
	output trigger_pkg::stats_t stats_o
);

	trigger_pkg::stats_t stats_q;

	// count in the low bits, msb latches once they wrap
	function automatic trigger_pkg::stat_cnt_t bump(
		input trigger_pkg::stat_cnt_t cnt,
		input logic inc
	);
		trigger_pkg::stat_cnt_t nxt;
		nxt = cnt;
		if (inc) begin
			nxt[`UDPT_CNT_W-2:0] = cnt[`UDPT_CNT_W-2:0] + 1'b1;
			if (&cnt[`UDPT_CNT_W-2:0]) begin
				nxt[`UDPT_CNT_W-1] = 1'b1;
			end
		end
		return nxt;
	endfunction

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			stats_q <= '0;
		end else if (clear_i) begin
			stats_q <= '0;
		end else begin
			stats_q.frames_in <= bump(stats_q.frames_in, frame_done_i);
			stats_q.frames_matched <= bump(stats_q.frames_matched, frame_matched_i);
			stats_q.samples_queued <= bump(stats_q.samples_queued, queued_i);
			stats_q.samples_dropped <= bump(stats_q.samples_dropped, dropped_i);
		end
	end

	assign stats_o = stats_q;

endmodule

//--- hw/udp_trigger_top.sv
// ------------------------------------------------------------
// udp trigger tap top level
// stream passthrough plus parser, realignment, sample queue
// and statistics
// ------------------------------------------------------------
`timescale 1ns/1ps

module udp_trigger_top (
	input  logic                   axis_aclk,
	input  logic                   cf_rstn,
	input  stream_pkg::axis_beat_t s_beat_i,
	input  logic                   s_tvalid_i,
	output logic                   s_tready_o,
	output stream_pkg::axis_beat_t m_beat_o,
	output logic                   m_tvalid_o,
	input  logic                   m_tready_i,
	output trigger_pkg::sample_t   sample_o,
	output logic                   sample_req_o,
	input  logic                   sample_ack_i,
	output trigger_pkg::stats_t    stats_o,
	input  logic                   clear_i
);

	logic beat_fire;
	logic hdr0_en;
	logic hdr1_en;
	logic sample_en;
	logic load_en;
	logic ip_udp_ok;
	logic port_ok;
	logic frame_done;
	logic frame_matched;
	logic queued;
	logic dropped;
	logic sample_valid;
	trigger_pkg::sample_t sample;

	// straight passthrough, downstream ready goes back upstream
	assign m_beat_o = s_beat_i;
	assign m_tvalid_o = s_tvalid_i;
	assign s_tready_o = m_tready_i;
	assign beat_fire = s_tvalid_i & m_tready_i;

	frame_ctrl u_frame_ctrl (
		.axis_aclk       (axis_aclk),
		.cf_rstn         (cf_rstn),
		.beat_fire_i     (beat_fire),
		.beat_last_i     (s_beat_i.last),
		.ip_udp_ok_i     (ip_udp_ok),
		.port_ok_i       (port_ok),
		.hdr0_en_o       (hdr0_en),
		.hdr1_en_o       (hdr1_en),
		.sample_en_o     (sample_en),
		.load_en_o       (load_en),
		.frame_done_o    (frame_done),
		.frame_matched_o (frame_matched)
	);

	header_match u_header_match (
		.axis_aclk   (axis_aclk),
		.cf_rstn     (cf_rstn),
		.beat_i      (s_beat_i.data),
		.hdr0_en_i   (hdr0_en),
		.hdr1_en_i   (hdr1_en),
		.ip_udp_ok_o (ip_udp_ok),
		.port_ok_o   (port_ok)
	);

	payload_align u_payload_align (
		.axis_aclk      (axis_aclk),
		.cf_rstn        (cf_rstn),
		.beat_i         (s_beat_i.data),
		.load_en_i      (load_en),
		.sample_en_i    (sample_en),
		.sample_o       (sample),
		.sample_valid_o (sample_valid)
	);

	sample_queue u_sample_queue (
		.axis_aclk      (axis_aclk),
		.cf_rstn        (cf_rstn),
		.sample_i       (sample),
		.sample_valid_i (sample_valid),
		.sample_o       (sample_o),
		.sample_req_o   (sample_req_o),
		.sample_ack_i   (sample_ack_i),
		.queued_o       (queued),
		.dropped_o      (dropped)
	);

	traffic_counters u_traffic_counters (
		.axis_aclk       (axis_aclk),
		.cf_rstn         (cf_rstn),
		.clear_i         (clear_i),
		.frame_done_i    (frame_done),
		.frame_matched_i (frame_matched),
		.queued_i        (queued),
		.dropped_i       (dropped),
		.stats_o         (stats_o)
	);

endmodule

//--- verif/tb_frames.svh
// ------------------------------------------------------------
// testbench helpers: lcg source, frame building and sending,
// timed waits, value, sample and stats comparison
// ------------------------------------------------------------
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

task automatic expect_equal(input string name, input logic [255:0] exp,
	input logic [255:0] act);
	assert (exp === act) else begin
		errors++;
		$display("ERR %s expected %h actual %h", name, exp, act);
	end
endtask

// header fields forced over random payload
task automatic build_frame(input int n, input logic [15:0] eth, input logic [7:0] proto,
	input logic [15:0] port);
	stream_pkg::tdata_t d;
	int i;
	int w;
	frame_q.delete();
	for (i = 0; i < n; i++) begin
		for (w = 0; w < 8; w++) begin
			d[w*32 +: 32] = lcg_next();
		end
		if (i == 0) begin
			d[`UDPT_ETH_TYPE_POS +: 16] = eth;
			d[`UDPT_IP_PROTO_POS +: 8] = proto;
		end
		if (i == 1) begin
			d[`UDPT_UDP_DPORT_POS +: 16] = port;
		end
		frame_q.push_back(d);
	end
endtask

// holds the beat until an edge sees valid and ready together
task automatic drive_beat(input stream_pkg::tdata_t data, input logic last);
	int tries;
	logic accepted;
	s_beat_i.data = data;
	s_beat_i.keep = '1;
	s_beat_i.user = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
	s_beat_i.last = last;
	s_tvalid_i = 1'b1;
	accepted = 1'b0;
	tries = 0;
	while (!accepted && tries < 50) begin
		m_tready_i = !random_ready || ((lcg_next() & 32'h3000_0000) != 0);
		accepted = m_tready_i;
		@(posedge axis_aclk);
		#2;
		tries++;
	end
	if (!accepted) begin
		timeouts++;
		$display("timeout: a beat was not accepted within 50 cycles");
	end
endtask

// sample k is low bits of beat k over the top of beat k-1
task automatic send_frame(input bit hit);
	stream_pkg::tdata_t cur;
	stream_pkg::tdata_t prv;
	int k;
	for (k = 0; k < frame_q.size(); k++) begin
		cur = frame_q[k];
		drive_beat(cur, k == frame_q.size() - 1);
		if (hit && k >= 2) begin
			prv = frame_q[k-1];
			exp_q.push_back({cur[`UDPT_SPLIT-1:0], prv[`UDPT_DATA_W-1:`UDPT_SPLIT]});
		end
	end
	s_tvalid_i = 1'b0;
	s_beat_i.last = 1'b0;
	m_tready_i = 1'b1;
endtask

task automatic run_frame(input int n, input logic [15:0] eth, input logic [7:0] proto,
	input logic [15:0] port);
	bit hit;
	int samples;
	int kept;
	hit = eth == `UDPT_IP_TYPE && proto == `UDPT_UDP_PROTO && port == `UDPT_TRIG_PORT;
	samples = (hit && n > 2) ? n - 2 : 0;
	// a stalled consumer leaves room for one queue's worth
	kept = (ack_stall && samples > `UDPT_QUEUE_DEPTH) ? `UDPT_QUEUE_DEPTH : samples;
	build_frame(n, eth, proto, port);
	send_frame(hit);
	n_frames++;
	if (samples > 0) begin
		n_matched++;
	end
	n_queued += kept;
	n_dropped += samples - kept;
endtask

task automatic idle(input int n);
	repeat (n) begin
		@(posedge axis_aclk);
		#2;
	end
endtask

task automatic wait_samples(input int n);
	int cycles;
	cycles = 0;
	while (recv_q.size() < n && cycles < 200) begin
		@(posedge axis_aclk);
		#2;
		cycles++;
	end
	if (recv_q.size() < n) begin
		timeouts++;
		$display("timeout: only %0d of %0d samples arrived on the sample port",
			recv_q.size(), n);
	end
endtask

task automatic compare_samples(input string name);
	int k;
	expect_equal({name, " sample count"}, exp_q.size(), recv_q.size());
	for (k = 0; k < exp_q.size() && k < recv_q.size(); k++) begin
		expect_equal(name, exp_q[k], recv_q[k]);
	end
	exp_q.delete();
	recv_q.delete();
endtask

task automatic verify_stats(input string name);
	expect_equal({name, " frames_in"}, n_frames, stats_o.frames_in);
	expect_equal({name, " frames_matched"}, n_matched, stats_o.frames_matched);
	expect_equal({name, " samples_queued"}, n_queued, stats_o.samples_queued);
	expect_equal({name, " samples_dropped"}, n_dropped, stats_o.samples_dropped);
endtask

`endif

//--- verif/tb_udp_trigger.sv
// ------------------------------------------------------------
// testbench for the udp trigger tap
// clock, reset, DUT, sample port responder, protocol
// assertions and directed frame tests
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "udp_trigger_macros.svh"

module tb_udp_trigger;

	logic axis_aclk;
	logic cf_rstn;
	stream_pkg::axis_beat_t s_beat_i;
	logic s_tvalid_i;
	logic s_tready_o;
	stream_pkg::axis_beat_t m_beat_o;
	logic m_tvalid_o;
	logic m_tready_i;
	trigger_pkg::sample_t sample_o;
	logic sample_req_o;
	logic sample_ack_i;
	trigger_pkg::stats_t stats_o;
	logic clear_i;

	logic [31:0] lcg_state;
	logic random_ready;
	logic ack_stall;
	logic prev_req;
	logic prev_ack;
	trigger_pkg::sample_t prev_sample;
	stream_pkg::tdata_t frame_q[$];
	trigger_pkg::sample_t exp_q[$];
	trigger_pkg::sample_t recv_q[$];
	int errors;
	int assert_fails;
	int timeouts;
	int n_frames;
	int n_matched;
	int n_queued;
	int n_dropped;
	int n;

	udp_trigger_top DUT (.*);

	`include "tb_frames.svh"

	initial axis_aclk = 1'b0;
	always #10 axis_aclk = ~axis_aclk;

	// sampled mid-cycle, away from edges and input changes
	always @(negedge axis_aclk) begin
		assert (m_beat_o == s_beat_i && m_tvalid_o == s_tvalid_i && s_tready_o == m_tready_i)
		else begin
			assert_fails++;
			$display("passthrough output differs from the slave side at %0t", $time);
		end
		if (cf_rstn) begin
			assert (!(sample_req_o && !prev_req && prev_ack)) else begin
				assert_fails++;
				$display("sample request rose while ack was still high at %0t", $time);
			end
			assert (!(sample_req_o && prev_req) || sample_o == prev_sample) else begin
				assert_fails++;
				$display("sample data changed while request was high at %0t", $time);
			end
		end
		prev_req = sample_req_o;
		prev_ack = sample_ack_i;
		prev_sample = sample_o;
	end

	// consumer side of the four-phase port
	always @(posedge axis_aclk) begin
		#2;
		if (cf_rstn) begin
			if (!sample_ack_i && prev_req && !ack_stall) begin
				recv_q.push_back(sample_o);
				sample_ack_i = 1'b1;
			end else if (sample_ack_i && !prev_req) begin
				sample_ack_i = 1'b0;
			end
		end
	end

	initial begin
		lcg_state = 32'd3474;
		cf_rstn = 1'b0;
		s_beat_i = '0;
		s_tvalid_i = 1'b0;
		m_tready_i = 1'b1;
		sample_ack_i = 1'b0;
		clear_i = 1'b0;
		random_ready = 1'b0;
		ack_stall = 1'b0;
		prev_req = 1'b0;
		prev_ack = 1'b0;
		prev_sample = '0;
		errors = 0;
		assert_fails = 0;
		timeouts = 0;
		n_frames = 0;
		n_matched = 0;
		n_queued = 0;
		n_dropped = 0;
		repeat (4) @(posedge axis_aclk);
		#2;
		cf_rstn = 1'b1;
		expect_equal("reset req", 0, sample_req_o);
		verify_stats("reset");

		// matching frames of growing length, random downstream ready
		random_ready = 1'b1;
		for (n = 3; n <= 6; n++) begin
			run_frame(n, `UDPT_IP_TYPE, `UDPT_UDP_PROTO, `UDPT_TRIG_PORT);
			wait_samples(exp_q.size());
			compare_samples("match");
		end
		verify_stats("match");

		// each field wrong once, then a header-only frame
		run_frame(5, 16'h0608, `UDPT_UDP_PROTO, `UDPT_TRIG_PORT);
		run_frame(5, `UDPT_IP_TYPE, 8'h06, `UDPT_TRIG_PORT);
		run_frame(5, `UDPT_IP_TYPE, `UDPT_UDP_PROTO, 16'd12346);
		run_frame(2, `UDPT_IP_TYPE, `UDPT_UDP_PROTO, `UDPT_TRIG_PORT);
		idle(10);
		compare_samples("no match");
		verify_stats("no match");

		// consumer stalled, queue overflows
		random_ready = 1'b0;
		ack_stall = 1'b1;
		run_frame(8, `UDPT_IP_TYPE, `UDPT_UDP_PROTO, `UDPT_TRIG_PORT);
		idle(6);
		// head entry stays offered while the consumer holds off
		expect_equal("stall hold", 1, sample_req_o);
		verify_stats("stall");
		while (exp_q.size() > `UDPT_QUEUE_DEPTH) begin
			void'(exp_q.pop_back());
		end
		ack_stall = 1'b0;
		wait_samples(exp_q.size());
		idle(20);
		compare_samples("stall");

		clear_i = 1'b1;
		idle(1);
		clear_i = 1'b0;
		n_frames = 0;
		n_matched = 0;
		n_queued = 0;
		n_dropped = 0;
		verify_stats("clear");
		run_frame(4, `UDPT_IP_TYPE, `UDPT_UDP_PROTO, `UDPT_TRIG_PORT);
		wait_samples(exp_q.size());
		compare_samples("after clear");
		verify_stats("after clear");

		$display("check errors: %0d, assertion failures: %0d, timeouts: %0d",
			errors, assert_fails, timeouts);
		if (errors == 0 && assert_fails == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+hw
+incdir+verif
hw/stream_pkg.sv
hw/trigger_pkg.sv
hw/frame_ctrl.sv
hw/header_match.sv
hw/payload_align.sv
hw/sample_queue.sv
hw/traffic_counters.sv
hw/udp_trigger_top.sv
verif/tb_udp_trigger.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_udp_trigger
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
